// ==== logic/loader_pkg.sv ====
/*
 * loader package
 * shared constants and bus types of the serial download port:
 * command codes, byte memory geometry, the received byte record
 * and the memory write record
 */

package loader_pkg;

	// ******************************
	// memory geometry
	// ******************************

	// 14-bit byte address, 16 kbyte memory
	localparam int ram_aw    = 14;
	localparam int ram_depth = 1 << ram_aw;

	// width of the downloaded byte count
	localparam int size_w = 16;

	// ******************************
	// host command codes
	// ******************************

	// file transfer control, payload bit 0 starts or ends a download
	localparam logic [7:0] cmd_file_tx  = 8'h53;
	// file data, every payload byte goes to the next address
	localparam logic [7:0] cmd_file_dat = 8'h54;
	// set base, high byte then low byte of the next start address
	localparam logic [7:0] cmd_set_base = 8'h55;

	// ******************************
	// bus records
	// ******************************

	// one received byte, valid is a single-cycle pulse
	typedef struct packed {
		logic       valid;
		logic       first;
		logic [7:0] data;
	} spi_byte_t;

	// one memory write, taken unconditionally by the memory
	typedef struct packed {
		logic              valid;
		logic [ram_aw-1:0] addr;
		logic [7:0]        data;
	} ram_wr_t;

endpackage

// ==== logic/spi_byte_rx.sv ====
/*
 * serial byte receiver
 * shifts sdi in msb first, one bit per sck edge while sel is high,
 * and presents each completed byte for one cycle. the first byte
 * of a frame is flagged as the command byte. dropping sel throws
 * away a partial byte and rearms the command flag
 */

`timescale 1ns/100ps

module spi_byte_rx (
	input  logic                  sck,
	input  logic                  ss,
	input  logic                  sel,
	input  logic                  sdi,
	output loader_pkg::spi_byte_t rx_byte
);

	// ******************************
	// receive state
	// ******************************

	// seven earlier bits of the current byte
	logic [6:0] shift_q;
	// position of the next bit inside the byte
	logic [2:0] bit_cnt;
	// no byte completed yet in this frame
	logic       no_byte_yet;

	// registered output byte
	logic       byte_valid;
	logic       byte_first;
	logic [7:0] byte_data;

	// ******************************
	// bit counter and byte strobe
	// ******************************

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			bit_cnt     <= '0;
			no_byte_yet <= 1'b1;
			byte_valid  <= 1'b0;
			byte_first  <= 1'b0;
		end else begin
			// strobe lasts a single cycle
			byte_valid <= 1'b0;
			if (!sel) begin
				// frame gap, partial byte is lost
				bit_cnt     <= '0;
				no_byte_yet <= 1'b1;
			end else begin
				// wraps from 7 back to 0 for the next byte
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					byte_valid  <= 1'b1;
					byte_first  <= no_byte_yet;
					no_byte_yet <= 1'b0;
				end
			end
		end
	end

	// ******************************
	// shift register
	// ******************************

	always_ff @(posedge sck) begin
		if (sel) begin
			shift_q <= {shift_q[5:0], sdi};
			// eighth bit is taken straight from the line
			if (bit_cnt == 3'd7)
				byte_data <= {shift_q, sdi};
		end
	end

	assign rx_byte = '{valid: byte_valid, first: byte_first, data: byte_data};

endmodule

// ==== logic/load_ctrl.sv ====
/*
 * load controller
 * decodes the command byte of each frame and the payload that
 * follows it. holds the base, write address, byte count and
 * downloading flag, and turns file data bytes into memory writes
 */

`timescale 1ns/100ps

module load_ctrl (
	input  logic                          sck,
	input  logic                          ss,
	input  logic                          sel,
	input  loader_pkg::spi_byte_t         rx_byte,
	output loader_pkg::ram_wr_t           ram_wr,
	output logic                          downloading,
	output logic [loader_pkg::size_w-1:0] size
);

	import loader_pkg::*;

	// ******************************
	// register set
	// ******************************

	// command of the current frame, zero when idle
	logic [7:0]        cmd_q;
	// payload byte index, saturates at 3
	logic [1:0]        idx_q;
	// start address of the next download
	logic [ram_aw-1:0] base_q;
	// high set-base byte waiting for the low one
	logic [7:0]        base_hi_q;
	// address of the next data byte
	logic [ram_aw-1:0] wr_ptr;

	// write port register
	logic              wr_valid;
	logic [ram_aw-1:0] wr_addr;
	logic [7:0]        wr_data;

	// data byte that really goes to memory
	logic              take_data;

	assign take_data = rx_byte.valid && !rx_byte.first &&
		(cmd_q == cmd_file_dat) && downloading;

	// ******************************
	// command decode
	// ******************************

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			cmd_q       <= '0;
			idx_q       <= '0;
			base_q      <= '0;
			wr_ptr      <= '0;
			downloading <= 1'b0;
			size        <= '0;
			wr_valid    <= 1'b0;
		end else begin
			wr_valid <= take_data;
			if (rx_byte.valid) begin
				if (rx_byte.first) begin
					// new frame, latch its command
					cmd_q <= rx_byte.data;
					idx_q <= '0;
				end else begin
					if (idx_q != 2'd3)
						idx_q <= idx_q + 2'd1;
					// control payload, only the first byte counts
					if (cmd_q == cmd_file_tx && idx_q == 2'd0) begin
						if (rx_byte.data[0]) begin
							wr_ptr      <= base_q;
							size        <= '0;
							downloading <= 1'b1;
						end else begin
							// size keeps the final count
							downloading <= 1'b0;
						end
					end
					// low set-base byte completes the address
					if (cmd_q == cmd_set_base && idx_q == 2'd1)
						base_q <= {base_hi_q[5:0], rx_byte.data};
					// address wraps at the top of memory
					if (take_data) begin
						wr_ptr <= wr_ptr + ram_aw'(1);
						size   <= size + size_w'(1);
					end
				end
			end else if (!sel) begin
				// between frames nothing is decoded
				cmd_q <= '0;
				idx_q <= '0;
			end
		end
	end

	// ******************************
	// payload registers
	// ******************************

	always_ff @(posedge sck) begin
		if (rx_byte.valid && !rx_byte.first && cmd_q == cmd_set_base && idx_q == 2'd0)
			base_hi_q <= rx_byte.data;
		if (take_data) begin
			wr_addr <= wr_ptr;
			wr_data <= rx_byte.data;
		end
	end

	assign ram_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

// ==== logic/load_ram.sv ====
/*
 * download memory
 * byte array written by the load controller, one write per cycle
 * at most, with a registered read port for the processor side.
 * a read of the address being written returns the old byte
 */

`timescale 1ns/100ps

module load_ram (
	input  logic                          sck,
	input  loader_pkg::ram_wr_t           ram_wr,
	input  logic [loader_pkg::ram_aw-1:0] rd_addr,
	output logic [7:0]                    rd_data
);

	import loader_pkg::*;

	// ******************************
	// storage
	// ******************************

	// contents undefined until written
	logic [7:0] mem [ram_depth];

	// ******************************
	// write port
	// ******************************

	// write is never refused
	always_ff @(posedge sck) begin
		if (ram_wr.valid)
			mem[ram_wr.addr] <= ram_wr.data;
	end

	// ******************************
	// read port
	// ******************************

	// one cycle of latency, read before write on a collision
	always_ff @(posedge sck) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== logic/data_loader.sv ====
/*
 * serial download port
 * the host shifts commands and file data in on sdi framed by sel,
 * the data lands in an on-chip byte memory that the processor
 * reads back through rd_addr and rd_data
 */

`timescale 1ns/100ps

module data_loader (
	input  logic                          sck,
	input  logic                          ss,
	input  logic                          sel,
	input  logic                          sdi,
	input  logic [loader_pkg::ram_aw-1:0] rd_addr,
	output logic                          downloading,
	output logic [loader_pkg::size_w-1:0] size,
	output logic [7:0]                    rd_data
);

	import loader_pkg::*;

	// received bytes into the controller
	spi_byte_t rx_byte;
	// memory writes from the controller
	ram_wr_t   ram_wr;

	// serial line to bytes
	spi_byte_rx spi_byte_rx_inst (
		.sck     (sck),
		.ss      (ss),
		.sel     (sel),
		.sdi     (sdi),
		.rx_byte (rx_byte)
	);

	// command decode and register set
	load_ctrl load_ctrl_inst (
		.sck         (sck),
		.ss          (ss),
		.sel         (sel),
		.rx_byte     (rx_byte),
		.ram_wr      (ram_wr),
		.downloading (downloading),
		.size        (size)
	);

	// byte memory
	load_ram load_ram_inst (
		.sck     (sck),
		.ram_wr  (ram_wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

// ==== tb/loader_checker.sv ====
/*
 * load controller checker
 * concurrent rules on the write port, the byte count and the
 * received byte strobe, bound into the load controller
 */

`timescale 1ns/100ps

module loader_checker (
	input  logic                          sck,
	input  logic                          ss,
	input  loader_pkg::spi_byte_t         rx_byte,
	input  loader_pkg::ram_wr_t           ram_wr,
	input  logic                          downloading,
	input  logic [loader_pkg::size_w-1:0] size
);

	import loader_pkg::*;

	// a memory write only happens inside a download
	wr_needs_dl: assert property (@(posedge sck) disable iff (ss)
		ram_wr.valid |-> downloading)
		else $error("memory write while downloading is low");

	// count and write valid are loaded on the same edge
	size_steps: assert property (@(posedge sck) disable iff (ss)
		ram_wr.valid |-> size == size_w'($past(size) + 1'b1))
		else $error("size did not step by one with a memory write");

	// bytes arrive at least eight cycles apart
	byte_gap: assert property (@(posedge sck) disable iff (ss)
		rx_byte.valid |=> !rx_byte.valid)
		else $error("byte strobe high on two cycles in a row");

endmodule

// ==== tb/loader_monitor.sv ====
/*
 * loader monitor
 * decodes sel and sdi into a reference model of the download port
 * and compares the flag, the byte count and the read-back data
 */

`timescale 1ns/100ps

module loader_monitor (
	input  logic                          sck,
	input  logic                          ss,
	input  logic                          sel,
	input  logic                          sdi,
	input  logic                          rd_en,
	input  logic [loader_pkg::ram_aw-1:0] rd_addr,
	input  logic                          downloading,
	input  logic [loader_pkg::size_w-1:0] size,
	input  logic [7:0]                    rd_data,
	output int                            err_cnt,
	output int                            rd_cnt
);

	import loader_pkg::*;

	// register set of the model
	typedef struct packed {
		logic              dl;
		logic [size_w-1:0] size;
		logic [ram_aw-1:0] base;
		logic [ram_aw-1:0] ptr;
		logic [7:0]        hi;
		logic [7:0]        cmd;
	} model_t;

	model_t            m;
	// snapshot waiting for its compare
	model_t            exp_m;
	int                chk_wait;
	int                bit_n;
	int                idx;
	logic              cmd_next;
	logic [7:0]        sh;
	logic              rd_en_d;
	logic [ram_aw-1:0] rd_addr_d;
	logic [7:0]        mem_m [ram_depth];
	// addresses that hold a downloaded byte
	bit                wr_m [ram_depth];

	task check_state();
		if (downloading !== exp_m.dl || size !== exp_m.size) begin
			err_cnt++;
			$display("ERR %0t: downloading %b size %0d, expected %b and %0d",
				$time, downloading, size, exp_m.dl, exp_m.size);
		end
	endtask

	// ******************************
	// byte decode
	// ******************************

	task take_byte(input logic [7:0] b);
		if (cmd_next) begin
			m.cmd    = b;
			idx      = 0;
			cmd_next = 1'b0;
		end else begin
			if (m.cmd == cmd_file_tx && idx == 0) begin
				m.dl = b[0];
				// a start rewinds pointer and count
				if (b[0]) begin
					m.ptr  = m.base;
					m.size = '0;
				end
			end
			if (m.cmd == cmd_set_base && idx == 0)
				m.hi = b;
			if (m.cmd == cmd_set_base && idx == 1)
				m.base = {m.hi[5:0], b};
			// 14-bit pointer wraps by itself
			if (m.cmd == cmd_file_dat && m.dl) begin
				mem_m[m.ptr] = b;
				wr_m[m.ptr]  = 1'b1;
				m.ptr        = m.ptr + 1'b1;
				m.size       = m.size + 1'b1;
			end
			idx++;
		end
		exp_m    = m;
		chk_wait = 2;
	endtask

	// sampled half a cycle before the edge where the DUT takes the bit
	always @(negedge sck) begin
		if (ss) begin
			m        = '0;
			exp_m    = '0;
			chk_wait = 2;
			bit_n    = 0;
			cmd_next = 1'b1;
			rd_en_d  = 1'b0;
		end else begin
			// flag and count settle two cycles after the byte
			if (chk_wait != 0) begin
				chk_wait--;
				if (chk_wait == 0)
					check_state();
			end
			// read data belongs to the address of one cycle earlier
			if (rd_en_d && wr_m[rd_addr_d]) begin
				rd_cnt++;
				if (rd_data !== mem_m[rd_addr_d]) begin
					err_cnt++;
					$display("ERR %0t: rd_data %h at %h, expected %h",
						$time, rd_data, rd_addr_d, mem_m[rd_addr_d]);
				end
			end
			rd_en_d   = rd_en;
			rd_addr_d = rd_addr;
			// sel low drops a partial byte, next byte is a command
			if (!sel) begin
				bit_n    = 0;
				cmd_next = 1'b1;
			end else begin
				sh = {sh[6:0], sdi};
				bit_n++;
				if (bit_n == 8) begin
					bit_n = 0;
					take_byte(sh);
				end
			end
		end
	end

endmodule

// ==== tb/tb_data_loader.sv ====
/*
 * testbench of the serial download port
 * random frames from an xorshift generator, then a read sweep
 * over the memory, with the monitor doing all comparing
 */

`timescale 1ns/100ps

module tb_data_loader;

	import loader_pkg::*;

	localparam int seed          = 69185;
	localparam int n_frames      = 60;
	// command plus 24 payload bytes and the longest gap
	localparam int max_frame_cyc = 8 * 25 + 5;
	localparam int t_clk         = 20;
	localparam int timeout_ns    = t_clk * (n_frames * max_frame_cyc + ram_depth + 100);

	logic              sck = 1'b0;
	logic              ss;
	logic              sel;
	logic              sdi;
	logic              rd_en;
	logic [ram_aw-1:0] rd_addr;
	logic              downloading;
	logic [size_w-1:0] size;
	logic [7:0]        rd_data;
	int                err_cnt;
	int                rd_cnt;
	logic [31:0]       rng;

	always #10 sck = ~sck;

	data_loader data_loader_inst (
		.sck         (sck),
		.ss          (ss),
		.sel         (sel),
		.sdi         (sdi),
		.rd_addr     (rd_addr),
		.downloading (downloading),
		.size        (size),
		.rd_data     (rd_data)
	);

	loader_monitor loader_monitor_inst (.*);

	bind load_ctrl loader_checker loader_checker_inst (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// sel low for n cycles, returns 2 ns after an edge
	task idle(input int n);
		sel = 1'b0;
		sdi = 1'b0;
		repeat (n) begin
			@(posedge sck);
			#2;
		end
	endtask

	// top nbits of b, msb first
	task shift_out(input logic [7:0] b, input int nbits);
		for (int i = 7; i > 7 - nbits; i--) begin
			sel = 1'b1;
			sdi = b[i];
			@(posedge sck);
			#2;
		end
	endtask

	// ******************************
	// random frames
	// ******************************

	task send_frame();
		logic [31:0]       r;
		logic [ram_aw-1:0] base;
		int                len;
		rng = xorshift(rng);
		r   = rng;
		case (r[2:0])
			// start on 0, end on 1
			3'd0, 3'd1: begin
				shift_out(cmd_file_tx, 8);
				shift_out({r[15:9], ~r[0]}, 8);
			end
			3'd2, 3'd3, 3'd4: begin
				len = 1 + int'(r[12:8] % 5'd24);
				shift_out(cmd_file_dat, 8);
				repeat (len) begin
					rng = xorshift(rng);
					shift_out(rng[7:0], 8);
				end
			end
			// now and then close to the top so a download wraps
			3'd5: begin
				base = r[21:8];
				if (r[22])
					base[ram_aw-1:5] = '1;
				shift_out(cmd_set_base, 8);
				shift_out({r[31:30], base[13:8]}, 8);
				shift_out(base[7:0], 8);
			end
			// unknown command with some payload
			3'd6: begin
				shift_out({4'h6, r[11:8]}, 8);
				repeat (1 + int'(r[13:12])) shift_out(r[31:24], 8);
			end
			// cut inside the command or inside the first payload byte
			default: begin
				if (r[8])
					shift_out(cmd_file_tx + 8'(r[10:9] % 2'd3), 8);
				shift_out(r[31:24], 1 + int'(r[13:11] % 3'd7));
			end
		endcase
	endtask

	initial begin
		ss      = 1'b1;
		sel     = 1'b0;
		sdi     = 1'b0;
		rd_en   = 1'b0;
		rd_addr = '0;
		rng     = 32'(seed);
		repeat (3) @(posedge sck);
		#2;
		ss = 1'b0;
		idle(4);
		for (int f = 0; f < n_frames; f++) begin
			send_frame();
			rng = xorshift(rng);
			idle(1 + int'(rng % 5));
		end
		idle(4);
		// read sweep, monitor checks the written addresses
		rd_en = 1'b1;
		for (int a = 0; a < ram_depth; a++) begin
			rd_addr = ram_aw'(a);
			idle(1);
		end
		rd_en = 1'b0;
		idle(3);
		$display("%0d errors, %0d bytes read back", err_cnt, rd_cnt);
		if (err_cnt == 0 && rd_cnt > 0) begin
			$display(">>> PASS");
		end else begin
			if (rd_cnt == 0)
				$display("no downloaded byte was read back");
			$display(">>> FAIL");
		end
		$finish;
	end

	// watchdog sized from the longest possible run
	initial begin
		#(timeout_ns);
		$display("simulation timed out");
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== flist.f ====
logic/loader_pkg.sv
logic/spi_byte_rx.sv
logic/load_ctrl.sv
logic/load_ram.sv
logic/data_loader.sv
tb/loader_checker.sv
tb/loader_monitor.sv
tb/tb_data_loader.sv

// ==== run.sh ====
#!/bin/sh
# build and run the download port testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_data_loader -f flist.f
out=$(./obj_dir/Vtb_data_loader || true)
echo "$out"
echo "$out" | grep -qxF '>>> PASS'
